//--- source/frame_pkg.sv
package frame_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] word16_t;

    // Fixed header values
    localparam word16_t ETHER_TYPE_IPV4   = 16'h0800;
    localparam byte_t   IPV4_VERSION_IHL  = 8'h45;
    localparam byte_t   IPV4_DSCP         = 8'h00;
    localparam byte_t   IPV4_TTL          = 8'h80;
    localparam byte_t   IPV4_PROTOCOL_UDP = 8'h11;

    // Section sizes in bytes
    localparam int IPV4_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES  = 8;
    localparam int ETH_HEADER_BYTES  = 14;
    localparam int MIN_FRAME_BYTES   = 60;

    typedef enum logic [3:0] {
        S_IDLE,
        S_CHECKSUM_WAIT,
        S_MAC_DESTINATION,
        S_MAC_SOURCE,
        S_ETHER_TYPE,
        S_IPV4_HEADER,
        S_UDP_HEADER,
        S_PAYLOAD,
        S_PAD
    } producer_state_t;

endpackage

//--- source/ipv4_header_checksum.sv
`timescale 1ns/1ps

module ipv4_header_checksum (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  compute,
    input  frame_pkg::word16_t    total_length,
    input  frame_pkg::word16_t    identification,
    input  frame_pkg::word16_t    flags,
    input  frame_pkg::ipv4_addr_t source,
    input  frame_pkg::ipv4_addr_t destination,
    output frame_pkg::word16_t    checksum
);

    import frame_pkg::*;

    word16_t [9:0] header_words;
    logic [19:0]   sum_wide;
    logic [16:0]   sum_fold;
    word16_t       sum_final;

    // Checksum field itself counts as zero
    assign header_words = {
        {IPV4_VERSION_IHL, IPV4_DSCP},
        total_length,
        identification,
        flags,
        {IPV4_TTL, IPV4_PROTOCOL_UDP},
        16'h0000,
        source[31:16],
        source[15:0],
        destination[31:16],
        destination[15:0]
    };

    always_comb begin
        sum_wide = '0;
        for (int i = 0; i < 10; i++) begin
            sum_wide = sum_wide + 20'(header_words[i]);
        end
        // Two folds cover the carry of ten words
        sum_fold  = 17'(sum_wide[15:0]) + 17'(sum_wide[19:16]);
        sum_final = sum_fold[15:0] + 16'(sum_fold[16]);
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            checksum <= '0;
        end else if (compute) begin
            checksum <= ~sum_final;
        end
    end

endmodule

//--- source/credit_byte_fifo.sv
`timescale 1ns/1ps

module credit_byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             push,
    input  frame_pkg::byte_t push_data,
    input  logic             push_last,
    input  logic             pop,
    output frame_pkg::byte_t pop_data,
    output logic             pop_last,
    output logic             not_empty
);

    localparam int POINTER_WIDTH = $clog2(FIFO_DEPTH);
    localparam int COUNT_WIDTH   = $clog2(FIFO_DEPTH + 1);

    // Last flag above the byte
    logic [8:0]               storage [FIFO_DEPTH];
    logic [POINTER_WIDTH-1:0] write_pointer;
    logic [POINTER_WIDTH-1:0] read_pointer;
    logic [COUNT_WIDTH-1:0]   count;

    assign not_empty            = (count != '0);
    assign {pop_last, pop_data} = storage[read_pointer];

    always_ff @(posedge clock) begin
        if (push) begin
            storage[write_pointer] <= {push_last, push_data};
        end
    end

    // Pointers wrap on their own at a power of two depth
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (push) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (pop) begin
                read_pointer <= read_pointer + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer credits keep the buffer from overflowing
    assert property (@(posedge clock) disable iff (!reset_n)
        push |-> count != COUNT_WIDTH'(FIFO_DEPTH));

    assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> not_empty);

endmodule

//--- source/frame_egress.sv
`timescale 1ns/1ps

module frame_egress (
    input  logic             clock,
    input  logic             reset_n,
    input  frame_pkg::byte_t pop_data,
    input  logic             pop_last,
    input  logic             not_empty,
    input  logic             frame_ready,
    output logic             pop,
    output logic             credit_return,
    output frame_pkg::byte_t frame_data,
    output logic             frame_valid,
    output logic             frame_last
);

    // Refill when the output register is empty or drains this cycle
    assign pop = not_empty && (!frame_valid || frame_ready);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            frame_valid   <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
            if (pop) begin
                frame_valid <= 1'b1;
            end else if (frame_ready) begin
                frame_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            frame_data <= pop_data;
            frame_last <= pop_last;
        end
    end

    // Held byte stays put until the sink takes it
    assert property (@(posedge clock) disable iff (!reset_n)
        frame_valid && !frame_ready |=>
            frame_valid && $stable(frame_data) && $stable(frame_last));

endmodule

//--- source/udp_frame_producer.sv
`timescale 1ns/1ps

module udp_frame_producer #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  start,
    input  frame_pkg::mac_t       mac_destination,
    input  frame_pkg::mac_t       mac_source,
    input  frame_pkg::ipv4_addr_t ipv4_source,
    input  frame_pkg::ipv4_addr_t ipv4_destination,
    input  frame_pkg::word16_t    ipv4_identification,
    input  frame_pkg::word16_t    ipv4_flags,
    input  frame_pkg::word16_t    udp_source,
    input  frame_pkg::word16_t    udp_destination,
    input  frame_pkg::word16_t    udp_checksum,
    input  frame_pkg::word16_t    udp_payload_size,
    input  frame_pkg::byte_t      payload_read_data,
    input  logic                  credit_return,
    output logic                  ready,
    output frame_pkg::word16_t    payload_read_address,
    output logic                  push,
    output frame_pkg::byte_t      push_data,
    output logic                  push_last
);

    import frame_pkg::*;

    localparam int CREDIT_WIDTH = $clog2(FIFO_DEPTH + 1);

    producer_state_t         state;
    producer_state_t         field_next;
    logic [CREDIT_WIDTH-1:0] credits;
    logic [4:0]              field_index;
    logic [4:0]              field_last_index;
    logic [159:0]            field_vector;
    byte_t                   header_byte;
    word16_t                 ipv4_checksum;
    word16_t                 frame_bytes;
    mac_t                    saved_mac_destination;
    mac_t                    saved_mac_source;
    ipv4_addr_t              saved_ipv4_source;
    ipv4_addr_t              saved_ipv4_destination;
    word16_t                 saved_ipv4_identification;
    word16_t                 saved_ipv4_flags;
    word16_t                 saved_udp_source;
    word16_t                 saved_udp_destination;
    word16_t                 saved_udp_checksum;
    word16_t                 saved_payload_size;
    word16_t                 ipv4_total_length;
    word16_t                 udp_length;
    logic                    pad_needed;
    logic [4:0]              pad_last_index;
    logic                    accept;
    logic                    credit_ok;
    logic                    header_push;
    logic                    read_issue;
    logic                    pad_push;
    logic                    spend;
    logic                    read_pending;
    logic                    read_final;

    ////////////////////
    // Field latch

    assign frame_bytes = udp_payload_size
                       + 16'(ETH_HEADER_BYTES + IPV4_HEADER_BYTES + UDP_HEADER_BYTES);

    always_ff @(posedge clock) begin
        if (accept) begin
            saved_mac_destination     <= mac_destination;
            saved_mac_source          <= mac_source;
            saved_ipv4_source         <= ipv4_source;
            saved_ipv4_destination    <= ipv4_destination;
            saved_ipv4_identification <= ipv4_identification;
            saved_ipv4_flags          <= ipv4_flags;
            saved_udp_source          <= udp_source;
            saved_udp_destination     <= udp_destination;
            saved_udp_checksum        <= udp_checksum;
            saved_payload_size        <= udp_payload_size;
            ipv4_total_length <= udp_payload_size + 16'(IPV4_HEADER_BYTES + UDP_HEADER_BYTES);
            udp_length        <= udp_payload_size + 16'(UDP_HEADER_BYTES);
            pad_needed        <= frame_bytes < 16'(MIN_FRAME_BYTES);
            pad_last_index    <= 5'(16'(MIN_FRAME_BYTES - 1) - frame_bytes);
        end
    end

    ipv4_header_checksum checksum_unit (
        .clock          (clock),
        .reset_n        (reset_n),
        .compute        (state == S_CHECKSUM_WAIT),
        .total_length   (ipv4_total_length),
        .identification (saved_ipv4_identification),
        .flags          (saved_ipv4_flags),
        .source         (saved_ipv4_source),
        .destination    (saved_ipv4_destination),
        .checksum       (ipv4_checksum)
    );

    ////////////////////
    // Header byte select

    // Each field left aligned, sent from the top byte down
    always_comb begin
        field_vector     = '0;
        field_last_index = '0;
        field_next       = S_IDLE;
        case (state)
            S_MAC_DESTINATION: begin
                field_vector     = {saved_mac_destination, 112'd0};
                field_last_index = 5'd5;
                field_next       = S_MAC_SOURCE;
            end
            S_MAC_SOURCE: begin
                field_vector     = {saved_mac_source, 112'd0};
                field_last_index = 5'd5;
                field_next       = S_ETHER_TYPE;
            end
            S_ETHER_TYPE: begin
                field_vector     = {ETHER_TYPE_IPV4, 144'd0};
                field_last_index = 5'd1;
                field_next       = S_IPV4_HEADER;
            end
            S_IPV4_HEADER: begin
                field_vector     = {IPV4_VERSION_IHL, IPV4_DSCP, ipv4_total_length,
                                    saved_ipv4_identification, saved_ipv4_flags,
                                    IPV4_TTL, IPV4_PROTOCOL_UDP, ipv4_checksum,
                                    saved_ipv4_source, saved_ipv4_destination};
                field_last_index = 5'(IPV4_HEADER_BYTES - 1);
                field_next       = S_UDP_HEADER;
            end
            S_UDP_HEADER: begin
                field_vector     = {saved_udp_source, saved_udp_destination,
                                    udp_length, saved_udp_checksum, 96'd0};
                field_last_index = 5'(UDP_HEADER_BYTES - 1);
                field_next       = (saved_payload_size != '0) ? S_PAYLOAD : S_PAD;
            end
            default: begin
            end
        endcase
    end

    // Zero in the pad state
    assign header_byte = field_vector[159 - 8 * field_index -: 8];

    ////////////////////
    // Credits and push

    assign ready       = (state == S_IDLE);
    assign accept      = start && ready;
    assign credit_ok   = (credits != '0);
    assign header_push = credit_ok && (state inside {S_MAC_DESTINATION, S_MAC_SOURCE,
                                                     S_ETHER_TYPE, S_IPV4_HEADER, S_UDP_HEADER});
    assign read_issue  = credit_ok && (state == S_PAYLOAD)
                      && (payload_read_address != saved_payload_size);
    assign pad_push    = credit_ok && (state == S_PAD);
    assign spend       = header_push || read_issue || pad_push;

    // Payload byte lands a cycle after its read, its credit already spent
    assign push      = header_push || read_pending || pad_push;
    assign push_data = read_pending ? payload_read_data : header_byte;
    assign push_last = (read_pending && read_final && !pad_needed)
                    || (pad_push && field_index == pad_last_index);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state                <= S_IDLE;
            field_index          <= '0;
            credits              <= CREDIT_WIDTH'(FIFO_DEPTH);
            payload_read_address <= '0;
            read_pending         <= 1'b0;
            read_final           <= 1'b0;
        end else begin
            credits      <= credits + CREDIT_WIDTH'(credit_return) - CREDIT_WIDTH'(spend);
            read_pending <= read_issue;
            read_final   <= read_issue && (payload_read_address == saved_payload_size - 16'd1);
            if (read_issue) begin
                payload_read_address <= payload_read_address + 16'd1;
            end
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        payload_read_address <= '0;
                        state                <= S_CHECKSUM_WAIT;
                    end
                end
                S_CHECKSUM_WAIT: begin
                    field_index <= '0;
                    state       <= S_MAC_DESTINATION;
                end
                S_PAYLOAD: begin
                    if (read_pending && read_final) begin
                        field_index <= '0;
                        state       <= pad_needed ? S_PAD : S_IDLE;
                    end
                end
                S_PAD: begin
                    if (pad_push) begin
                        if (field_index == pad_last_index) begin
                            state <= S_IDLE;
                        end else begin
                            field_index <= field_index + 5'd1;
                        end
                    end
                end
                default: begin
                    if (header_push) begin
                        if (field_index == field_last_index) begin
                            field_index <= '0;
                            state       <= field_next;
                        end else begin
                            field_index <= field_index + 5'd1;
                        end
                    end
                end
            endcase
        end
    end

    // Egress returns no more than was spent
    assert property (@(posedge clock) disable iff (!reset_n)
        credits <= CREDIT_WIDTH'(FIFO_DEPTH));

endmodule

//--- source/udp_frame_generator.sv
`timescale 1ns/1ps

module udp_frame_generator #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  start,
    input  frame_pkg::mac_t       mac_destination,
    input  frame_pkg::mac_t       mac_source,
    input  frame_pkg::ipv4_addr_t ipv4_source,
    input  frame_pkg::ipv4_addr_t ipv4_destination,
    input  frame_pkg::word16_t    ipv4_identification,
    input  frame_pkg::word16_t    ipv4_flags,
    input  frame_pkg::word16_t    udp_source,
    input  frame_pkg::word16_t    udp_destination,
    input  frame_pkg::word16_t    udp_checksum,
    input  frame_pkg::word16_t    udp_payload_size,
    input  frame_pkg::byte_t      payload_read_data,
    input  logic                  frame_ready,
    output logic                  ready,
    output frame_pkg::word16_t    payload_read_address,
    output frame_pkg::byte_t      frame_data,
    output logic                  frame_valid,
    output logic                  frame_last
);

    import frame_pkg::*;

    // Producer to buffer
    logic  push;
    byte_t push_data;
    logic  push_last;

    // Buffer to egress
    logic  pop;
    byte_t pop_data;
    logic  pop_last;
    logic  not_empty;
    logic  credit_return;

    udp_frame_producer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) producer (.*);

    credit_byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) buffer (.*);

    frame_egress egress (.*);

endmodule

//--- include/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Bytes on the wire, padded to the Ethernet minimum
function automatic int model_frame_length(input frame_pkg::word16_t payload_size);
    int length;
    length = 42 + int'(payload_size);
    return (length < frame_pkg::MIN_FRAME_BYTES) ? frame_pkg::MIN_FRAME_BYTES : length;
endfunction

function automatic frame_pkg::word16_t model_ipv4_checksum(
    input frame_pkg::word16_t    total_length,
    input frame_pkg::word16_t    identification,
    input frame_pkg::word16_t    flags,
    input frame_pkg::ipv4_addr_t source,
    input frame_pkg::ipv4_addr_t destination
);
    int unsigned sum;
    sum = 32'h4500 + total_length + identification + flags + 32'h8011
        + source[31:16] + source[15:0] + destination[31:16] + destination[15:0];
    while (sum > 32'hffff) begin
        sum = (sum & 32'hffff) + (sum >> 16);
    end
    return ~sum[15:0];
endfunction

// Expected byte at position index of the frame
function automatic frame_pkg::byte_t model_frame_byte(
    input int                    index,
    input frame_pkg::mac_t       mac_destination,
    input frame_pkg::mac_t       mac_source,
    input frame_pkg::ipv4_addr_t source,
    input frame_pkg::ipv4_addr_t destination,
    input frame_pkg::word16_t    identification,
    input frame_pkg::word16_t    flags,
    input frame_pkg::word16_t    udp_source,
    input frame_pkg::word16_t    udp_destination,
    input frame_pkg::word16_t    udp_checksum,
    input frame_pkg::word16_t    payload_size
);
    frame_pkg::word16_t total_length;
    logic [335:0]       header;
    total_length = payload_size + 16'd28;
    header = {mac_destination, mac_source, 16'h0800, 16'h4500, total_length,
              identification, flags, 16'h8011,
              model_ipv4_checksum(total_length, identification, flags, source, destination),
              source, destination, udp_source, udp_destination,
              payload_size + 16'd8, udp_checksum};
    if (index < 42) begin
        return header[335 - 8 * index -: 8];
    end
    if (index < 42 + int'(payload_size)) begin
        return 8'(index - 42) ^ 8'((index - 42) >> 8) ^ 8'ha5;
    end
    return 8'h00;
endfunction

`endif

//--- dv/tb_udp_frame_generator.sv
`timescale 1ns/1ps

module tb_udp_frame_generator;

    import frame_pkg::*;

    `include "tb_frame_model.svh"

    localparam int NUM_FRAMES = 5;

    logic       clock = 1'b0;
    logic       reset_n;
    logic       start;
    mac_t       mac_destination;
    mac_t       mac_source;
    ipv4_addr_t ipv4_source;
    ipv4_addr_t ipv4_destination;
    word16_t    ipv4_identification;
    word16_t    ipv4_flags;
    word16_t    udp_source;
    word16_t    udp_destination;
    word16_t    udp_checksum;
    word16_t    udp_payload_size;
    byte_t      payload_read_data = '0;
    logic       frame_ready = 1'b0;
    logic       ready;
    word16_t    payload_read_address;
    byte_t      frame_data;
    logic       frame_valid;
    logic       frame_last;

    // Fields of each frame in the run
    mac_t       field_mac_destination [NUM_FRAMES];
    mac_t       field_mac_source [NUM_FRAMES];
    ipv4_addr_t field_ipv4_source [NUM_FRAMES];
    ipv4_addr_t field_ipv4_destination [NUM_FRAMES];
    word16_t    field_ipv4_identification [NUM_FRAMES];
    word16_t    field_ipv4_flags [NUM_FRAMES];
    word16_t    field_udp_source [NUM_FRAMES];
    word16_t    field_udp_destination [NUM_FRAMES];
    word16_t    field_udp_checksum [NUM_FRAMES];
    word16_t    field_payload_size [NUM_FRAMES];

    logic [31:0] rng_state = 32'hc534_0093;
    word16_t     read_address_seen;
    int          rx_frame;
    int          rx_byte;
    int          total_bytes;
    byte_t       expected_data;
    logic        expected_last;
    logic        transfer;

    udp_frame_generator #(
        .FIFO_DEPTH (4)
    ) dut (.*);

    always #4 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_error(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic run_watchdog(input int limit_ns);
        #(limit_ns);
        report_error("Watchdog timeout, the frames did not all arrive in time");
    endtask

    ////////////////////
    // Payload memory and sink

    // Address seen mid cycle, data back one cycle later
    always @(negedge clock) begin
        read_address_seen = payload_read_address;
    end

    always @(posedge clock) begin
        #1;
        payload_read_data = read_address_seen[7:0] ^ read_address_seen[15:8] ^ 8'ha5;
    end

    // Sink accepts about three cycles in four
    always @(posedge clock) begin
        #1;
        rng_state   = lcg_next(rng_state);
        frame_ready = (rng_state[31:30] != 2'b00);
    end

    ////////////////////
    // Expected stream

    assign transfer = frame_valid && frame_ready;

    always_comb begin
        expected_data = 8'h00;
        expected_last = 1'b0;
        if (rx_frame < NUM_FRAMES) begin
            expected_data = model_frame_byte(rx_byte, field_mac_destination[rx_frame],
                field_mac_source[rx_frame], field_ipv4_source[rx_frame],
                field_ipv4_destination[rx_frame], field_ipv4_identification[rx_frame],
                field_ipv4_flags[rx_frame], field_udp_source[rx_frame],
                field_udp_destination[rx_frame], field_udp_checksum[rx_frame],
                field_payload_size[rx_frame]);
            expected_last = (rx_byte == model_frame_length(field_payload_size[rx_frame]) - 1);
        end
    end

    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rx_frame <= 0;
            rx_byte  <= 0;
        end else if (transfer && rx_frame < NUM_FRAMES) begin
            if (expected_last) begin
                rx_frame <= rx_frame + 1;
                rx_byte  <= 0;
            end else begin
                rx_byte <= rx_byte + 1;
            end
        end
    end

    idle_after_reset: assert property (@(posedge clock) $rose(reset_n) |-> ready && !frame_valid)
        else report_error("DUT not idle after reset, ready low or frame_valid high");

    no_extra_bytes: assert property (@(posedge clock) disable iff (!reset_n)
        transfer |-> rx_frame < NUM_FRAMES)
        else report_error("Byte transferred after the last expected frame");

    data_matches: assert property (@(posedge clock) disable iff (!reset_n)
        transfer |-> frame_data == expected_data)
        else report_error($sformatf("[ERROR] frame_data: got %02h expected %02h (frame %0d byte %0d)",
            $sampled(frame_data), $sampled(expected_data), $sampled(rx_frame), $sampled(rx_byte)));

    last_matches: assert property (@(posedge clock) disable iff (!reset_n)
        transfer |-> frame_last == expected_last)
        else report_error($sformatf("[ERROR] frame_last: got %h expected %h (frame %0d byte %0d)",
            $sampled(frame_last), $sampled(expected_last), $sampled(rx_frame), $sampled(rx_byte)));

    held_while_stalled: assert property (@(posedge clock) disable iff (!reset_n)
        frame_valid && !frame_ready |=>
            frame_valid && $stable(frame_data) && $stable(frame_last))
        else report_error($sformatf("[ERROR] frame_data/frame_last moved while stalled: now %02h/%h",
            $sampled(frame_data), $sampled(frame_last)));

    ////////////////////
    // Stimulus

    // Caller sits 1 ns after a rising edge
    task automatic start_frame(input int k);
        while (!ready) begin
            @(posedge clock);
            #1;
        end
        mac_destination     = field_mac_destination[k];
        mac_source          = field_mac_source[k];
        ipv4_source         = field_ipv4_source[k];
        ipv4_destination    = field_ipv4_destination[k];
        ipv4_identification = field_ipv4_identification[k];
        ipv4_flags          = field_ipv4_flags[k];
        udp_source          = field_udp_source[k];
        udp_destination     = field_udp_destination[k];
        udp_checksum        = field_udp_checksum[k];
        udp_payload_size    = field_payload_size[k];
        start               = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_frames(input int count);
        while (rx_frame < count) begin
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        reset_n             = 1'b0;
        start               = 1'b0;
        mac_destination     = '0;
        mac_source          = '0;
        ipv4_source         = '0;
        ipv4_destination    = '0;
        ipv4_identification = '0;
        ipv4_flags          = '0;
        udp_source          = '0;
        udp_destination     = '0;
        udp_checksum        = '0;
        udp_payload_size    = '0;
        total_bytes         = 0;

        // Short padded, long unpadded, then three back to back
        field_payload_size = '{16'd10, 16'd40, 16'd17, 16'd40, 16'd5};
        for (int k = 0; k < NUM_FRAMES; k++) begin
            field_mac_destination[k]     = 48'h0200_5e10_0000 + 48'(k * 257);
            field_mac_source[k]          = 48'h0a1b_2c3d_4e50 ^ 48'(k);
            field_ipv4_source[k]         = 32'hc0a8_0001 + 32'(k * 3);
            field_ipv4_destination[k]    = 32'hfffe_0a0a - 32'(k * 4099);
            field_ipv4_identification[k] = 16'h1c46 + 16'(k * 4369);
            field_ipv4_flags[k]          = k[0] ? 16'h4000 : 16'h0000;
            field_udp_source[k]          = 16'hc350 + 16'(k);
            field_udp_destination[k]     = 16'h0035 + 16'(k * 256);
            field_udp_checksum[k]        = 16'hbe00 ^ 16'(k);
            total_bytes += model_frame_length(field_payload_size[k]);
        end
        fork
            run_watchdog(4 * total_bytes * 8 + 16 * 8 + 2000);
        join_none

        repeat (16) @(posedge clock);
        #1;
        reset_n = 1'b1;

        start_frame(0);
        wait_frames(1);
        start_frame(1);
        wait_frames(2);
        for (int k = 2; k < NUM_FRAMES; k++) begin
            start_frame(k);
        end
        wait_frames(NUM_FRAMES);
        repeat (20) @(posedge clock);

        if (rx_frame == NUM_FRAMES && !frame_valid && ready) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_error("Stream did not settle idle after the last frame");
        end
    end

endmodule

//--- all.f
+incdir+include
source/frame_pkg.sv
source/ipv4_header_checksum.sv
source/credit_byte_fifo.sv
source/frame_egress.sv
source/udp_frame_producer.sv
source/udp_frame_generator.sv
dv/tb_udp_frame_generator.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_udp_frame_generator \
    -f all.f -o sim_udp_frame || { echo "Build failed"; exit 1; }
./obj_dir/sim_udp_frame > sim.log 2>&1 || true
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
